/* project.f */
verilog/crtc_pkg.sv
verilog/raster_pkg.sv
verilog/raster_timing.sv
verilog/crtc_regs.sv
verilog/crtc_core.sv
verilog/framestore_arbiter.sv
verilog/framestore_ram.sv
verilog/video_subsystem.sv
testbench/video_subsystem_chk.sv
testbench/video_subsystem_mon.sv
testbench/video_subsystem_tb.sv

/* testbench/video_subsystem_chk.sv */
module video_subsystem_chk (
	input logic PIXELCLK,
	input logic nRESET,
	input logic host_read,
	input logic host_rdata_valid,
	input logic cursor,
	input logic disen,
	input logic fetch_req,
	input logic char_valid
);

	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;    // Read by the testbench at the end.

	// ########################################
	// Handshake and cursor properties
	// ########################################
	assert property (@(posedge PIXELCLK) disable iff (!nRESET)
		host_rdata_valid == $past(host_read))
	else begin
		$error("host_rdata_valid does not follow host_read by one cycle");
		fail_count++;
	end

	assert property (@(posedge PIXELCLK) disable iff (!nRESET) cursor |-> disen)
	else begin
		$error("cursor is high outside the display enable");
		fail_count++;
	end

	assert property (@(posedge PIXELCLK) disable iff (!nRESET) fetch_req |-> ##2 char_valid)
	else begin
		$error("char_valid missing two cycles after fetch_req");
		fail_count++;
	end

endmodule

bind video_subsystem video_subsystem_chk chk_i (
	.PIXELCLK(PIXELCLK),
	.nRESET(nRESET),
	.host_read(host_read),
	.host_rdata_valid(host_rdata_valid),
	.cursor(cursor),
	.disen(disen),
	.fetch_req(fetch_req),
	.char_valid(char_valid)
);

/* testbench/video_subsystem_mon.sv */
module video_subsystem_mon import crtc_pkg::*; #(
	parameter int H_ACTIVE   = 64,
	parameter int H_TOTAL    = 80,
	parameter int H_SYNC     = 8,
	parameter int V_ACTIVE   = 24,
	parameter int V_TOTAL    = 30,
	parameter int V_SYNC     = 2,
	parameter int CHAR_WIDTH = 4
) (
	input  logic                    PIXELCLK,
	input  logic                    nRESET,
	input  logic                    h_sync,
	input  logic                    v_sync,
	input  logic                    disen,
	input  logic                    cursor,
	input  logic [row_width-1:0]    scanline_row,
	input  logic [fs_adr_width-1:0] framestore_adr,
	input  logic                    char_valid,
	input  logic [data_width-1:0]   char_data,
	input  logic                    host_read,
	input  logic [data_width-1:0]   host_rdata,
	input  logic                    host_rdata_valid,
	input  logic [data_width-1:0]   exp_rdata,
	input  logic                    fs_write,
	input  logic [fs_adr_width-1:0] fs_wadr,
	input  logic [data_width-1:0]   fs_wdata,
	input  int                      cfg_horz,
	input  int                      cfg_vert,
	input  int                      cfg_maxsl,
	input  int                      cfg_cstart,
	input  int                      cfg_cend,
	input  logic [blink_width-1:0]  cfg_blink,
	input  int                      cfg_start,
	input  int                      cfg_cursor,
	output int                      errors
);

	timeunit 1ns;
	timeprecision 1ps;

	logic [data_width-1:0]   model [2**fs_adr_width];    // Framestore contents.
	logic [data_width-1:0]   exp_d1, exp_d2, exp_rd;
	logic [fs_adr_width-1:0] exp_adr;
	logic                    hs_prev, vs_prev, disen_prev, frame_seen, rd_wait, exp_cur;
	int                      hs_len, hs_gap, vs_len, vs_gap, line_cnt, char_cyc;
	int                      row, exp_lines, exp_px;

	initial begin
		errors     = 0;
		hs_prev    = 0;
		vs_prev    = 0;
		disen_prev = 0;
		frame_seen = 0;
		rd_wait    = 0;
		hs_len     = 0;
		hs_gap     = -1;
		vs_len     = 0;
		vs_gap     = -1;
		line_cnt   = 0;
		char_cyc   = 0;
	end

	task automatic value_error(input string name, input longint exp, input longint got);
		$display("Fail at %0t ns: %s expected %0h got %0h", $time, name, exp, got);
		errors++;
	endtask

	task automatic event_error(input string what);
		$display("Error at %0t ns: %s", $time, what);
		errors++;
	endtask

	always @(posedge PIXELCLK) begin
		if (nRESET) begin
			// ########################################
			// Sync widths and periods
			// ########################################
			if (hs_gap >= 0) hs_gap++;
			if (hs_prev && !h_sync && hs_len != H_SYNC) begin
				value_error("h_sync width", H_SYNC, hs_len);
			end
			if (!h_sync) hs_len = 0;
			else hs_len++;
			if (h_sync && !hs_prev) begin
				if (hs_gap > 0 && hs_gap != H_TOTAL) begin
					value_error("h_sync period", H_TOTAL, hs_gap);
				end
				hs_gap = 0;
			end
			if (vs_gap >= 0) vs_gap++;
			if (vs_prev && !v_sync && vs_len != V_SYNC * H_TOTAL)
				value_error("v_sync width", V_SYNC * H_TOTAL, vs_len);
			if (!v_sync) vs_len = 0;
			else vs_len++;

			// Frame totals use the settings of the frame just ended.
			if (!v_sync) begin
				exp_px    = (cfg_horz < H_ACTIVE / CHAR_WIDTH) ? cfg_horz * CHAR_WIDTH :
					(H_ACTIVE / CHAR_WIDTH) * CHAR_WIDTH;
				exp_lines = cfg_vert * (cfg_maxsl + 1);
				if (exp_lines > V_ACTIVE) exp_lines = V_ACTIVE;
				if (cfg_horz == 0) exp_lines = 0;
			end
			if (v_sync && !vs_prev) begin
				if (vs_gap > 0 && vs_gap != V_TOTAL * H_TOTAL)
					value_error("v_sync period", V_TOTAL * H_TOTAL, vs_gap);
				if (frame_seen && line_cnt != exp_lines) begin
					value_error("disen lines", exp_lines, line_cnt);
				end
				vs_gap     = 0;
				frame_seen = 1;
				line_cnt   = 0;
				char_cyc   = 0;
			end

			// ########################################
			// Display window, address and cursor
			// ########################################
			row     = line_cnt % (cfg_maxsl + 1);
			exp_adr = fs_adr_width'(cfg_start + (line_cnt / (cfg_maxsl + 1)) * cfg_horz
				+ char_cyc / CHAR_WIDTH);
			exp_cur = disen && (exp_adr == fs_adr_width'(cfg_cursor)) &&
				(row >= cfg_cstart) && (row <= cfg_cend);
			if (disen && frame_seen) begin
				if (scanline_row != row) value_error("scanline_row", row, scanline_row);
				if (framestore_adr != exp_adr) begin
					value_error("framestore_adr", exp_adr, framestore_adr);
				end
				char_cyc++;
			end else if (disen_prev) begin
				if (char_cyc != exp_px) value_error("disen pixels", exp_px, char_cyc);
				line_cnt++;
				char_cyc = 0;
			end
			if (cfg_blink == blink_on && cursor !== exp_cur) begin
				value_error("cursor", exp_cur, cursor);
			end
			if (cfg_blink == blink_off && cursor !== 1'b0) value_error("cursor", 0, cursor);

			// Fetched characters are compared with the model two cycles late.
			if (char_valid && char_data !== exp_d2) value_error("char_data", exp_d2, char_data);
			exp_d2 = exp_d1;
			exp_d1 = model[framestore_adr];

			if (rd_wait) begin
				if (!host_rdata_valid) event_error("no read data after host_read");
				else if (host_rdata !== exp_rd) value_error("host_rdata", exp_rd, host_rdata);
			end
			rd_wait    = host_read;
			exp_rd     = exp_rdata;
			hs_prev    = h_sync;
			vs_prev    = v_sync;
			disen_prev = disen;
		end
		if (fs_write) model[fs_wadr] = fs_wdata;    // After the fetch lookup.
	end

endmodule

/* testbench/video_subsystem_tb.sv */
module video_subsystem_tb import crtc_pkg::*; ;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int H_ACTIVE   = 64;
	localparam int H_FRONT    = 4;
	localparam int H_SYNC     = 8;
	localparam int H_BACK     = 4;
	localparam int V_ACTIVE   = 24;
	localparam int V_FRONT    = 2;
	localparam int V_SYNC     = 2;
	localparam int V_BACK     = 2;
	localparam int CHAR_WIDTH = 4;
	localparam int H_TOTAL    = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL    = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	localparam int FRAME      = H_TOTAL * V_TOTAL;
	localparam int NUM_ROWS   = 4;
	localparam int FILL_SIZE  = 384;    // Bytes filled before the first frame.
	localparam int CLK_PERIOD = 20;
	localparam int TIMEOUT    = ((NUM_ROWS * 2 + 1) * FRAME + 16) * CLK_PERIOD;

	typedef struct {
		int                     horz, vert, maxsl, cstart, cend;
		logic [blink_width-1:0] blink;
		int                     start, cur, exp_hi, exp_lo;
	} row_t;

	// ########################################
	// Stimulus table
	// ########################################
	row_t table_rows [NUM_ROWS] = '{
		'{16, 6, 3, 1, 2, blink_on,  0,   35,     0,    35},
		'{20, 5, 4, 0, 4, blink_on,  100, 145,    0,    145},    // Clipped both ways.
		'{10, 3, 7, 0, 7, blink_off, 200, 205,    0,    205},
		'{12, 2, 5, 2, 3, blink_on,  300, 'h1234, 'h12, 'h34}
	};

	logic                    PIXELCLK, nRESET;
	logic                    host_write, host_read, host_rs;
	logic [data_width-1:0]   host_wdata, host_rdata, exp_rdata;
	logic                    host_rdata_valid;
	logic                    fs_write;
	logic [fs_adr_width-1:0] fs_wadr;
	logic [data_width-1:0]   fs_wdata;
	logic                    h_sync, v_sync, disen, cursor, char_valid;
	logic [row_width-1:0]    scanline_row;
	logic [fs_adr_width-1:0] framestore_adr;
	logic [data_width-1:0]   char_data;
	int                      cfg_horz, cfg_vert, cfg_maxsl, cfg_cstart, cfg_cend;
	int                      cfg_start, cfg_cursor, mon_errors;
	logic [blink_width-1:0]  cfg_blink;

	video_subsystem #(
		.H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
		.V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
		.CHAR_WIDTH(CHAR_WIDTH)
	) video_subsystem_i (.*);

	video_subsystem_mon #(
		.H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL), .H_SYNC(H_SYNC), .V_ACTIVE(V_ACTIVE),
		.V_TOTAL(V_TOTAL), .V_SYNC(V_SYNC), .CHAR_WIDTH(CHAR_WIDTH)
	) video_subsystem_mon_i (.*, .errors(mon_errors));

	initial begin
		PIXELCLK = 1'b0;
		forever #(CLK_PERIOD / 2) PIXELCLK = ~PIXELCLK;
	end

	initial begin
		#(TIMEOUT);
		$display("Timeout: the run did not finish within %0d ns", TIMEOUT);
		$display("*** TEST FAILED ***");
		$finish;
	end

	task automatic tick();
		@(posedge PIXELCLK);
		#2;    // Inputs change just after the edge.
	endtask

	task automatic write_reg(input logic [reg_num_width-1:0] num, input logic [7:0] val);
		host_write = 1'b1;
		host_rs    = 1'b0;
		host_wdata = 8'(num);
		tick();
		host_rs    = 1'b1;
		host_wdata = val;
		tick();
		host_write = 1'b0;
	endtask

	task automatic read_reg(input logic [reg_num_width-1:0] num, input int exp);
		host_write = 1'b1;
		host_rs    = 1'b0;
		host_wdata = 8'(num);
		tick();
		host_write = 1'b0;
		host_read  = 1'b1;
		exp_rdata  = 8'(exp);
		tick();
		host_read  = 1'b0;
		tick();
	endtask

	task automatic put_char(input int adr, input int gap);
		fs_write = 1'b1;
		fs_wadr  = fs_adr_width'(adr);
		fs_wdata = 8'($urandom);
		tick();
		fs_write = 1'b0;
		repeat (gap - 1) tick();    // Host keeps one write per character.
	endtask

	task automatic program_row(input row_t t);
		cfg_horz   = t.horz;
		cfg_vert   = t.vert;
		cfg_maxsl  = t.maxsl;
		cfg_cstart = t.cstart;
		cfg_cend   = t.cend;
		cfg_blink  = t.blink;
		cfg_start  = t.start;
		cfg_cursor = t.cur;
		write_reg(reg_horz_display, 8'(t.horz));
		write_reg(reg_vert_display, 8'(t.vert));
		write_reg(reg_max_scanline, 8'(t.maxsl));
		write_reg(reg_cursor_start, {1'b0, t.blink, 5'(t.cstart)});
		write_reg(reg_cursor_end, 8'(t.cend));
		write_reg(reg_start_hi, 8'(t.start >> 8));
		write_reg(reg_start_lo, 8'(t.start));
		write_reg(reg_cursor_hi, 8'(t.cur >> 8));
		write_reg(reg_cursor_lo, 8'(t.cur));
		read_reg(reg_cursor_hi, t.exp_hi);
		read_reg(reg_cursor_lo, t.exp_lo);
		read_reg(reg_lightpen_hi, 0);
		read_reg(reg_lightpen_lo, 0);
	endtask

	// ########################################
	// Main sequence
	// ########################################
	initial begin
		void'($urandom(32'h188));
		nRESET     = 1'b0;
		host_write = 1'b0;
		host_read  = 1'b0;
		host_rs    = 1'b0;
		host_wdata = '0;
		exp_rdata  = '0;
		fs_write   = 1'b0;
		fs_wadr    = '0;
		fs_wdata   = '0;
		cfg_horz   = 0;
		cfg_vert   = 0;
		cfg_maxsl  = 0;
		cfg_cstart = 0;
		cfg_cend   = 0;
		cfg_blink  = blink_off;
		cfg_start  = 0;
		cfg_cursor = 0;
		repeat (16) @(posedge PIXELCLK);
		#2 nRESET = 1'b1;
		for (int i = 0; i < FILL_SIZE; i++) put_char(i, CHAR_WIDTH);
		@(posedge v_sync);
		#2;
		foreach (table_rows[r]) begin
			program_row(table_rows[r]);
			for (int i = 0; i < 64; i++) put_char($urandom % FILL_SIZE, 8);    // Into display.
			@(posedge v_sync);
			#2;
			repeat ($urandom % 500) tick();
			for (int i = 0; i < 64; i++) put_char($urandom % FILL_SIZE, CHAR_WIDTH + $urandom % 4);
			@(posedge v_sync);
			#2;
		end
		repeat (8) tick();
		$display("Errors: %0d monitor, %0d assertion", mon_errors,
			video_subsystem_i.chk_i.fail_count);
		if (mon_errors == 0 && video_subsystem_i.chk_i.fail_count == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

/* verilog/crtc_core.sv */
module crtc_core import crtc_pkg::*, raster_pkg::*; #(
	parameter int CHAR_WIDTH = default_char_width
) (
	input  logic                    PIXELCLK,
	input  logic                    nRESET,
	input  logic                    active,
	input  logic                    line_end,
	input  logic                    frame_end,
	input  logic [horz_width-1:0]   horz_display,
	input  logic [vert_width-1:0]   vert_display,
	input  logic [row_width-1:0]    max_scanline,
	input  logic [row_width-1:0]    cursor_start_row,
	input  logic [row_width-1:0]    cursor_end_row,
	input  logic [blink_width-1:0]  blink_mode,
	input  logic [fs_adr_width-1:0] start_address,
	input  logic [fs_adr_width-1:0] cursor_adr,
	output logic                    disen,
	output logic                    cursor,
	output logic [row_width-1:0]    scanline_row,
	output logic [fs_adr_width-1:0] framestore_adr,
	output logic                    fetch_req,
	output logic [fs_adr_width-1:0] fetch_adr
);

	localparam int PW = (CHAR_WIDTH > 1) ? $clog2(CHAR_WIDTH) : 1;
	localparam logic [PW-1:0] PHASE_LAST = PW'(CHAR_WIDTH - 1);

	logic [PW-1:0]           char_phase;
	logic                    char_en;
	logic [horz_width-1:0]   char_col;
	logic [vert_width-1:0]   char_row;
	logic                    show_char;
	logic                    next_row;
	logic [fs_adr_width-1:0] row_base;
	logic [fs_adr_width-1:0] next_base;
	logic [blink_width+2:0]  blink_cnt;
	logic                    cursor_show;

	// ########################################
	// Character enable and columns
	// ########################################
	always_ff @(posedge PIXELCLK) begin
		if (!nRESET || line_end || char_phase == PHASE_LAST) begin
			char_phase <= '0;    // Realigned to pixel 0 of every line.
		end else begin
			char_phase <= char_phase + 1'b1;
		end
	end

	assign char_en   = (char_phase == '0);
	assign show_char = active && (char_col < horz_display) && (char_row < vert_display);

	always_ff @(posedge PIXELCLK) begin
		if (!nRESET || line_end) begin
			char_col <= '0;
		end else if (char_en && active && char_col < horz_display) begin
			char_col <= char_col + 1'b1;    // Stops at the displayed width.
		end
	end

	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			disen     <= 1'b0;
			fetch_req <= 1'b0;
		end else begin
			fetch_req <= char_en && show_char;
			if (char_en) begin
				disen <= show_char;
			end
		end
	end

	// ########################################
	// Rows and framestore address
	// ########################################
	assign next_row  = line_end && (scanline_row == max_scanline);
	assign next_base = row_base + {{(fs_adr_width - horz_width){1'b0}}, horz_display};

	always_ff @(posedge PIXELCLK) begin
		if (!nRESET || frame_end) begin
			scanline_row <= '0;
			char_row     <= '0;
		end else if (next_row) begin
			scanline_row <= '0;
			if (char_row < vert_display) begin
				char_row <= char_row + 1'b1;
			end
		end else if (line_end) begin
			scanline_row <= scanline_row + 1'b1;
		end
	end

	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			framestore_adr <= '0;
			row_base       <= '0;
		end else if (frame_end) begin
			framestore_adr <= start_address;
			row_base       <= start_address;
		end else if (next_row) begin
			framestore_adr <= next_base;
			row_base       <= next_base;
		end else if (line_end) begin
			framestore_adr <= row_base;    // Same character row again.
		end else if (char_en && disen) begin
			framestore_adr <= framestore_adr + 1'b1;
		end
	end

	assign fetch_adr = framestore_adr;    // Valid with fetch_req.

	// ########################################
	// Cursor and blink
	// ########################################
	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			blink_cnt <= '0;
		end else if (frame_end) begin
			blink_cnt <= blink_cnt + 1'b1;
		end
	end

	always_comb begin
		case (blink_mode)
			blink_on:   cursor_show = 1'b1;
			blink_off:  cursor_show = 1'b0;
			blink_fast: cursor_show = blink_cnt[blink_fast_bit];
			blink_slow: cursor_show = blink_cnt[blink_slow_bit];
			default:    cursor_show = 1'b0;
		endcase
	end

	assign cursor = disen && cursor_show && (framestore_adr == cursor_adr) &&
		(scanline_row >= cursor_start_row) && (scanline_row <= cursor_end_row);

endmodule

/* verilog/crtc_pkg.sv */
package crtc_pkg;

	// ########################################
	// Field widths
	// ########################################
	localparam int fs_adr_width  = 14;    // Framestore address, 16K characters.
	localparam int reg_num_width = 5;     // Register number in the address register.
	localparam int data_width    = 8;     // Host data and character codes.
	localparam int horz_width    = 8;     // Displayed characters per row.
	localparam int vert_width    = 7;     // Displayed character rows.
	localparam int row_width     = 5;     // Scanline and cursor row fields.
	localparam int blink_width   = 2;     // Cursor blink mode field.

	// ########################################
	// Register numbers
	// ########################################
	localparam logic [reg_num_width-1:0] reg_horz_display = 5'd1;
	localparam logic [reg_num_width-1:0] reg_vert_display = 5'd6;
	localparam logic [reg_num_width-1:0] reg_max_scanline = 5'd9;
	localparam logic [reg_num_width-1:0] reg_cursor_start = 5'd10;    // Blink mode in bits 6:5.
	localparam logic [reg_num_width-1:0] reg_cursor_end   = 5'd11;
	localparam logic [reg_num_width-1:0] reg_start_hi     = 5'd12;
	localparam logic [reg_num_width-1:0] reg_start_lo     = 5'd13;
	localparam logic [reg_num_width-1:0] reg_cursor_hi    = 5'd14;
	localparam logic [reg_num_width-1:0] reg_cursor_lo    = 5'd15;
	localparam logic [reg_num_width-1:0] reg_lightpen_hi  = 5'd16;
	localparam logic [reg_num_width-1:0] reg_lightpen_lo  = 5'd17;

	// Cursor blink modes.
	localparam logic [blink_width-1:0] blink_on   = 2'd0;
	localparam logic [blink_width-1:0] blink_off  = 2'd1;
	localparam logic [blink_width-1:0] blink_fast = 2'd2;    // Toggles every 8 frames.
	localparam logic [blink_width-1:0] blink_slow = 2'd3;    // Toggles every 16 frames.
	localparam int blink_fast_bit = 3;
	localparam int blink_slow_bit = 4;

endpackage

/* verilog/crtc_regs.sv */
module crtc_regs import crtc_pkg::*; (
	input  logic                    PIXELCLK,
	input  logic                    nRESET,
	input  logic                    host_write,
	input  logic                    host_read,
	input  logic                    host_rs,
	input  logic [data_width-1:0]   host_wdata,
	output logic [data_width-1:0]   host_rdata,
	output logic                    host_rdata_valid,
	output logic [horz_width-1:0]   horz_display,
	output logic [vert_width-1:0]   vert_display,
	output logic [row_width-1:0]    max_scanline,
	output logic [row_width-1:0]    cursor_start_row,
	output logic [row_width-1:0]    cursor_end_row,
	output logic [blink_width-1:0]  blink_mode,
	output logic [fs_adr_width-1:0] start_address,
	output logic [fs_adr_width-1:0] cursor_adr
);

	localparam int HI_WIDTH = fs_adr_width - 8;    // Bits held in the high address registers.

	logic [reg_num_width-1:0] address_reg;
	logic [data_width-1:0]    rdata_mux;

	// ########################################
	// Write decode
	// ########################################
	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			address_reg      <= '0;
			horz_display     <= '0;
			vert_display     <= '0;
			max_scanline     <= '0;
			cursor_start_row <= '0;
			cursor_end_row   <= '0;
			blink_mode       <= '0;
			start_address    <= '0;
			cursor_adr       <= '0;
		end else if (host_write && !host_rs) begin
			address_reg <= host_wdata[reg_num_width-1:0];
		end else if (host_write) begin
			case (address_reg)    // Light pen and unknown numbers are dropped.
				reg_horz_display: horz_display <= host_wdata[horz_width-1:0];
				reg_vert_display: vert_display <= host_wdata[vert_width-1:0];
				reg_max_scanline: max_scanline <= host_wdata[row_width-1:0];
				reg_cursor_start: begin
					cursor_start_row <= host_wdata[row_width-1:0];
					blink_mode       <= host_wdata[6:5];
				end
				reg_cursor_end:   cursor_end_row <= host_wdata[row_width-1:0];
				reg_start_hi:     start_address[fs_adr_width-1:8] <= host_wdata[HI_WIDTH-1:0];
				reg_start_lo:     start_address[7:0] <= host_wdata;
				reg_cursor_hi:    cursor_adr[fs_adr_width-1:8] <= host_wdata[HI_WIDTH-1:0];
				reg_cursor_lo:    cursor_adr[7:0] <= host_wdata;
				default: ;
			endcase
		end
	end

	// ########################################
	// Read-back
	// ########################################
	always_comb begin
		case (address_reg)
			reg_cursor_hi:   rdata_mux = {{(data_width - HI_WIDTH){1'b0}},
				cursor_adr[fs_adr_width-1:8]};
			reg_cursor_lo:   rdata_mux = cursor_adr[7:0];
			reg_lightpen_hi: rdata_mux = '0;    // No light pen input.
			reg_lightpen_lo: rdata_mux = '0;
			default:         rdata_mux = '0;
		endcase
	end

	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			host_rdata_valid <= 1'b0;
		end else begin
			host_rdata_valid <= host_read;
		end
	end

	always_ff @(posedge PIXELCLK) begin
		if (host_read) begin
			host_rdata <= rdata_mux;    // Held until the next read.
		end
	end

endmodule

/* verilog/framestore_arbiter.sv */
module framestore_arbiter import crtc_pkg::*; (
	input  logic                    PIXELCLK,
	input  logic                    nRESET,
	input  logic                    fetch_req,
	input  logic [fs_adr_width-1:0] fetch_adr,
	input  logic                    fs_write,
	input  logic [fs_adr_width-1:0] fs_wadr,
	input  logic [data_width-1:0]   fs_wdata,
	input  logic [data_width-1:0]   ram_rdata,
	output logic                    ram_en,
	output logic                    ram_we,
	output logic [fs_adr_width-1:0] ram_adr,
	output logic [data_width-1:0]   ram_wdata,
	output logic                    char_valid,
	output logic [data_width-1:0]   char_data
);

	logic                    pend_valid;
	logic [fs_adr_width-1:0] pend_adr;
	logic [data_width-1:0]   pend_data;
	logic                    rd_pending;

	// ########################################
	// Port grant
	// ########################################
	assign ram_en    = fetch_req || fs_write || pend_valid;
	assign ram_we    = !fetch_req && (fs_write || pend_valid);    // Fetch always wins.
	assign ram_adr   = fetch_req ? fetch_adr : (pend_valid ? pend_adr : fs_wadr);
	assign ram_wdata = pend_valid ? pend_data : fs_wdata;

	// One-entry write buffer.
	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			pend_valid <= 1'b0;
		end else if (fs_write && (fetch_req || pend_valid)) begin
			pend_valid <= 1'b1;    // Port busy, park the write.
		end else if (!fetch_req) begin
			pend_valid <= 1'b0;
		end
	end

	always_ff @(posedge PIXELCLK) begin
		if (fs_write && (fetch_req || pend_valid)) begin
			pend_adr  <= fs_wadr;
			pend_data <= fs_wdata;
		end
	end

	// ########################################
	// Read return
	// ########################################
	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			rd_pending <= 1'b0;
			char_valid <= 1'b0;
		end else begin
			rd_pending <= fetch_req;     // RAM data out next cycle.
			char_valid <= rd_pending;
		end
	end

	always_ff @(posedge PIXELCLK) begin
		if (rd_pending) begin
			char_data <= ram_rdata;
		end
	end

endmodule

/* verilog/framestore_ram.sv */
module framestore_ram import crtc_pkg::*; (
	input  logic                    PIXELCLK,
	input  logic                    ram_en,
	input  logic                    ram_we,
	input  logic [fs_adr_width-1:0] ram_adr,
	input  logic [data_width-1:0]   ram_wdata,
	output logic [data_width-1:0]   ram_rdata
);

	localparam int DEPTH = 2 ** fs_adr_width;

	logic [data_width-1:0] mem [DEPTH];    // Character codes.

	// ########################################
	// Single port, write first
	// ########################################
	always_ff @(posedge PIXELCLK) begin
		if (ram_en) begin
			if (ram_we) begin
				mem[ram_adr] <= ram_wdata;
				ram_rdata    <= ram_wdata;    // New data on the read port.
			end else begin
				ram_rdata <= mem[ram_adr];
			end
		end
	end

endmodule

/* verilog/raster_pkg.sv */
package raster_pkg;

	// ########################################
	// Default 640x480 raster, pixel counts
	// ########################################
	localparam int default_h_active = 640;
	localparam int default_h_front  = 16;
	localparam int default_h_sync   = 96;
	localparam int default_h_back   = 48;

	// Vertical timing, line counts.
	localparam int default_v_active = 480;
	localparam int default_v_front  = 10;
	localparam int default_v_sync   = 2;
	localparam int default_v_back   = 33;

	// Pixels per character cell.
	localparam int default_char_width = 8;

endpackage

/* verilog/raster_timing.sv */
module raster_timing import raster_pkg::*; #(
	parameter int H_ACTIVE = default_h_active,
	parameter int H_FRONT  = default_h_front,
	parameter int H_SYNC   = default_h_sync,
	parameter int H_BACK   = default_h_back,
	parameter int V_ACTIVE = default_v_active,
	parameter int V_FRONT  = default_v_front,
	parameter int V_SYNC   = default_v_sync,
	parameter int V_BACK   = default_v_back
) (
	input  logic PIXELCLK,
	input  logic nRESET,
	output logic h_sync,
	output logic v_sync,
	output logic active,
	output logic line_end,
	output logic frame_end
);

	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	localparam int HW      = $clog2(H_TOTAL);
	localparam int VW      = $clog2(V_TOTAL);

	localparam logic [HW-1:0] H_LAST       = HW'(H_TOTAL - 1);
	localparam logic [HW-1:0] H_SYNC_START = HW'(H_ACTIVE + H_FRONT);
	localparam logic [HW-1:0] H_SYNC_END   = HW'(H_ACTIVE + H_FRONT + H_SYNC);
	localparam logic [VW-1:0] V_LAST       = VW'(V_TOTAL - 1);
	localparam logic [VW-1:0] V_SYNC_START = VW'(V_ACTIVE + V_FRONT);
	localparam logic [VW-1:0] V_SYNC_END   = VW'(V_ACTIVE + V_FRONT + V_SYNC);

	logic [HW-1:0] h_cnt;
	logic [VW-1:0] v_cnt;

	// ########################################
	// Pixel and line counters
	// ########################################
	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (line_end) begin
			h_cnt <= '0;
			v_cnt <= frame_end ? '0 : v_cnt + 1'b1;    // Line wraps with the frame.
		end else begin
			h_cnt <= h_cnt + 1'b1;
		end
	end

	// Decodes, counters are 0 during reset.
	assign line_end  = (h_cnt == H_LAST);
	assign frame_end = line_end && (v_cnt == V_LAST);
	assign active    = (h_cnt < HW'(H_ACTIVE)) && (v_cnt < VW'(V_ACTIVE));
	assign h_sync    = (h_cnt >= H_SYNC_START) && (h_cnt < H_SYNC_END);    // Positive pulse.
	assign v_sync    = (v_cnt >= V_SYNC_START) && (v_cnt < V_SYNC_END);

endmodule

/* verilog/video_subsystem.sv */
module video_subsystem import crtc_pkg::*, raster_pkg::*; #(
	parameter int H_ACTIVE   = default_h_active,
	parameter int H_FRONT    = default_h_front,
	parameter int H_SYNC     = default_h_sync,
	parameter int H_BACK     = default_h_back,
	parameter int V_ACTIVE   = default_v_active,
	parameter int V_FRONT    = default_v_front,
	parameter int V_SYNC     = default_v_sync,
	parameter int V_BACK     = default_v_back,
	parameter int CHAR_WIDTH = default_char_width
) (
	input  logic                    PIXELCLK,
	input  logic                    nRESET,
	input  logic                    host_write,
	input  logic                    host_read,
	input  logic                    host_rs,
	input  logic [data_width-1:0]   host_wdata,
	output logic [data_width-1:0]   host_rdata,
	output logic                    host_rdata_valid,
	input  logic                    fs_write,
	input  logic [fs_adr_width-1:0] fs_wadr,
	input  logic [data_width-1:0]   fs_wdata,
	output logic                    h_sync,
	output logic                    v_sync,
	output logic                    disen,
	output logic                    cursor,
	output logic [row_width-1:0]    scanline_row,
	output logic [fs_adr_width-1:0] framestore_adr,
	output logic                    char_valid,
	output logic [data_width-1:0]   char_data
);

	logic                    active, line_end, frame_end;
	logic [horz_width-1:0]   horz_display;
	logic [vert_width-1:0]   vert_display;
	logic [row_width-1:0]    max_scanline, cursor_start_row, cursor_end_row;
	logic [blink_width-1:0]  blink_mode;
	logic [fs_adr_width-1:0] start_address, cursor_adr;
	logic                    fetch_req;
	logic [fs_adr_width-1:0] fetch_adr;
	logic                    ram_en, ram_we;
	logic [fs_adr_width-1:0] ram_adr;
	logic [data_width-1:0]   ram_wdata, ram_rdata;

	// ########################################
	// Raster and CRTC
	// ########################################
	raster_timing #(
		.H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
		.V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
	) raster_timing_i (
		.PIXELCLK, .nRESET, .h_sync, .v_sync, .active, .line_end, .frame_end
	);

	crtc_regs crtc_regs_i (
		.PIXELCLK, .nRESET, .host_write, .host_read, .host_rs, .host_wdata,
		.host_rdata, .host_rdata_valid, .horz_display, .vert_display, .max_scanline,
		.cursor_start_row, .cursor_end_row, .blink_mode, .start_address, .cursor_adr
	);

	crtc_core #(
		.CHAR_WIDTH(CHAR_WIDTH)
	) crtc_core_i (
		.PIXELCLK, .nRESET, .active, .line_end, .frame_end,
		.horz_display, .vert_display, .max_scanline, .cursor_start_row,
		.cursor_end_row, .blink_mode, .start_address, .cursor_adr,
		.disen, .cursor, .scanline_row, .framestore_adr, .fetch_req, .fetch_adr
	);

	// ########################################
	// Framestore
	// ########################################
	framestore_arbiter framestore_arbiter_i (
		.PIXELCLK, .nRESET, .fetch_req, .fetch_adr, .fs_write, .fs_wadr, .fs_wdata,
		.ram_rdata, .ram_en, .ram_we, .ram_adr, .ram_wdata, .char_valid, .char_data
	);

	framestore_ram framestore_ram_i (
		.PIXELCLK, .ram_en, .ram_we, .ram_adr, .ram_wdata, .ram_rdata
	);

endmodule
